// File: fir_params.svh
`ifndef FIR_PARAMS_SVH
`define FIR_PARAMS_SVH

// bus and RAM widths
`define FIR_ADDR_W        12
`define FIR_DATA_W        32

// tap storage
`define FIR_MAX_TAPS      32
`define FIR_TAP_CNT_W     6

// ----------------------------------------
// register map
// ----------------------------------------
`define FIR_ADDR_CTRL     12'h000
`define FIR_ADDR_DLEN     12'h010
`define FIR_ADDR_TNUM     12'h014
`define FIR_ADDR_TAP_BASE 12'h080

`endif

// File: fir_cfg_pkg.sv
`default_nettype none

`include "fir_params.svh"

package fir_cfg_pkg;

    // read value of the control register
    typedef struct packed {
        logic ap_idle;
        logic ap_done;
        logic ap_start;
    } ap_status_t;

    typedef struct packed {
        logic [`FIR_DATA_W-1:0]    data_length;
        logic [`FIR_TAP_CNT_W-1:0] tap_num;
    } fir_cfg_t;

    // decoded AXI-Lite address kinds
    typedef enum logic [2:0] {
        SEL_CTRL,
        SEL_DLEN,
        SEL_TNUM,
        SEL_TAP,
        SEL_NONE
    } reg_sel_e;

endpackage

`default_nettype wire

// File: fir_data_pkg.sv
`default_nettype none

`include "fir_params.svh"

package fir_data_pkg;

    typedef logic signed [`FIR_DATA_W-1:0] sample_t;
    typedef logic signed [`FIR_DATA_W-1:0] coef_t;

    // one single-port block RAM access, byte address
    typedef struct packed {
        logic [3:0]             we;
        logic                   en;
        logic [`FIR_ADDR_W-1:0] addr;
        logic [`FIR_DATA_W-1:0] di;
    } bram_req_t;

    typedef enum logic [2:0] {
        ENG_IDLE,
        ENG_CLEAR,
        ENG_WAIT_IN,
        ENG_WRITE,
        ENG_MAC,
        ENG_OUT
    } eng_state_e;

endpackage

`default_nettype wire

// File: fir_axil_regs.sv
`default_nettype none

`include "fir_params.svh"

module fir_axil_regs (
    input  wire                          axis_clk,
    input  wire                          axis_rst_n,
    input  wire                          awvalid,
    input  wire [`FIR_ADDR_W-1:0]        awaddr,
    output logic                         awready,
    input  wire                          wvalid,
    input  wire [`FIR_DATA_W-1:0]        wdata,
    output logic                         wready,
    input  wire                          arvalid,
    input  wire [`FIR_ADDR_W-1:0]        araddr,
    output logic                         arready,
    output logic                         rvalid,
    input  wire                          rready,
    output logic [`FIR_DATA_W-1:0]       rdata,
    input  wire fir_cfg_pkg::ap_status_t status,
    input  wire                          busy,
    output fir_cfg_pkg::fir_cfg_t        cfg,
    output logic                         start_req,
    output logic                         done_clr,
    input  wire [`FIR_ADDR_W-1:0]        tap_rd_addr,
    input  wire fir_data_pkg::coef_t     tap_do,
    output fir_data_pkg::bram_req_t      tap_req
);

    fir_cfg_pkg::reg_sel_e wr_sel;
    fir_cfg_pkg::reg_sel_e ar_sel;
    fir_cfg_pkg::reg_sel_e rd_sel;
    logic                  wr_fire;
    logic                  ar_fire;
    logic                  rd_pend;
    logic                  rd_wait;

    function automatic fir_cfg_pkg::reg_sel_e decode_addr(input logic [`FIR_ADDR_W-1:0] addr);
        if (addr == `FIR_ADDR_CTRL)
            return fir_cfg_pkg::SEL_CTRL;
        if (addr == `FIR_ADDR_DLEN)
            return fir_cfg_pkg::SEL_DLEN;
        if (addr == `FIR_ADDR_TNUM)
            return fir_cfg_pkg::SEL_TNUM;
        if (addr >= `FIR_ADDR_TAP_BASE && addr < `FIR_ADDR_TAP_BASE + 4 * `FIR_MAX_TAPS)
            return fir_cfg_pkg::SEL_TAP;
        return fir_cfg_pkg::SEL_NONE;
    endfunction

    assign wr_sel  = decode_addr(awaddr);
    assign ar_sel  = decode_addr(araddr);
    assign wr_fire = awready && awvalid && wvalid;
    assign ar_fire = arready && arvalid;
    assign wready  = awready;

    // ----------------------------------------
    // write channel
    // ----------------------------------------
    // a pending read has priority, so a tap write never meets a tap read
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            awready <= 1'b0;
            cfg     <= '0;
        end else begin
            awready <= awvalid && wvalid && !awready && !arvalid && !rd_pend;
            if (wr_fire && !busy) begin
                case (wr_sel)
                    fir_cfg_pkg::SEL_DLEN: cfg.data_length <= wdata;
                    fir_cfg_pkg::SEL_TNUM: cfg.tap_num <= wdata[`FIR_TAP_CNT_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    assign start_req = wr_fire && wr_sel == fir_cfg_pkg::SEL_CTRL && wdata[0] && status.ap_idle;

    // ----------------------------------------
    // read channel
    // ----------------------------------------
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rd_pend <= 1'b0;
            rd_wait <= 1'b0;
            rd_sel  <= fir_cfg_pkg::SEL_NONE;
        end else begin
            arready <= arvalid && !arready && !rd_pend;
            if (ar_fire) begin
                rd_pend <= 1'b1;
                rd_wait <= 1'b1;
                rd_sel  <= ar_sel;
            end
            // tap RAM data arrives one cycle after the address
            if (rd_wait) begin
                rd_wait <= 1'b0;
                rvalid  <= 1'b1;
            end
            if (rvalid && rready) begin
                rvalid  <= 1'b0;
                rd_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (rd_wait) begin
            case (rd_sel)
                fir_cfg_pkg::SEL_CTRL: rdata <= {{(`FIR_DATA_W - 3){1'b0}}, status};
                fir_cfg_pkg::SEL_DLEN: rdata <= cfg.data_length;
                fir_cfg_pkg::SEL_TNUM:
                    rdata <= {{(`FIR_DATA_W - `FIR_TAP_CNT_W){1'b0}}, cfg.tap_num};
                fir_cfg_pkg::SEL_TAP:  rdata <= busy ? '0 : tap_do;
                default:               rdata <= '0;
            endcase
        end
    end

    // done is cleared with the same status value that was captured
    assign done_clr = rd_wait && rd_sel == fir_cfg_pkg::SEL_CTRL;

    // ----------------------------------------
    // tap RAM port
    // ----------------------------------------
    always_comb begin
        tap_req = '0;
        if (busy) begin
            tap_req.en   = 1'b1;
            tap_req.addr = tap_rd_addr;
        end else if (wr_fire && wr_sel == fir_cfg_pkg::SEL_TAP) begin
            tap_req.we   = 4'hf;
            tap_req.en   = 1'b1;
            tap_req.addr = awaddr - `FIR_ADDR_TAP_BASE;
            tap_req.di   = wdata;
        end else if (ar_fire && ar_sel == fir_cfg_pkg::SEL_TAP) begin
            tap_req.en   = 1'b1;
            tap_req.addr = araddr - `FIR_ADDR_TAP_BASE;
        end
    end

endmodule

`default_nettype wire

// File: fir_ap_ctrl.sv
`default_nettype none

module fir_ap_ctrl (
    input  wire                     axis_clk,
    input  wire                     axis_rst_n,
    input  wire                     start_req,
    input  wire                     done_clr,
    input  wire                     last_done,
    output fir_cfg_pkg::ap_status_t status,
    output logic                    start,
    output logic                    busy
);

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_RUN,
        CTRL_DONE
    } ctrl_state_e;

    ctrl_state_e state;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state <= CTRL_IDLE;
            start <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                CTRL_IDLE, CTRL_DONE: begin
                    if (start_req) begin
                        state <= CTRL_RUN;
                        start <= 1'b1;
                    end else if (done_clr) begin
                        state <= CTRL_IDLE;
                    end
                end
                CTRL_RUN: begin
                    if (last_done)
                        state <= CTRL_DONE;
                end
                default: state <= CTRL_IDLE;
            endcase
        end
    end

    // done stays up until a status read
    assign status.ap_idle  = state != CTRL_RUN;
    assign status.ap_done  = state == CTRL_DONE;
    assign status.ap_start = start;
    assign busy            = state == CTRL_RUN;

endmodule

`default_nettype wire

// File: fir_mac_engine.sv
`default_nettype none

`include "fir_params.svh"

module fir_mac_engine (
    input  wire                        axis_clk,
    input  wire                        axis_rst_n,
    input  wire                        start,
    input  wire fir_cfg_pkg::fir_cfg_t cfg,
    input  wire                        ss_tvalid,
    input  wire fir_data_pkg::sample_t ss_tdata,
    input  wire                        ss_tlast,
    output logic                       ss_tready,
    input  wire                        sm_tready,
    output logic                       sm_tvalid,
    output fir_data_pkg::sample_t      sm_tdata,
    output logic                       sm_tlast,
    input  wire fir_data_pkg::coef_t   tap_do,
    input  wire fir_data_pkg::sample_t data_do,
    output logic [`FIR_ADDR_W-1:0]     tap_rd_addr,
    output fir_data_pkg::bram_req_t    data_req,
    output logic                       last_done
);

    fir_data_pkg::eng_state_e  state;
    logic [`FIR_TAP_CNT_W-1:0] idx;
    logic [`FIR_TAP_CNT_W-1:0] hist_idx;
    logic [`FIR_TAP_CNT_W-1:0] ptr;
    logic [`FIR_TAP_CNT_W-1:0] last_idx;
    logic [`FIR_DATA_W-1:0]    in_cnt;
    logic [`FIR_DATA_W-1:0]    out_cnt;
    fir_data_pkg::sample_t     x_q;
    fir_data_pkg::sample_t     acc;
    fir_data_pkg::sample_t     prod;

    function automatic logic [`FIR_ADDR_W-1:0] word_addr(input logic [`FIR_TAP_CNT_W-1:0] i);
        return {{(`FIR_ADDR_W - `FIR_TAP_CNT_W - 2){1'b0}}, i, 2'b00};
    endfunction

    assign last_idx = cfg.tap_num - 1'b1;
    assign prod     = tap_do * data_do;

    // ----------------------------------------
    // sequencer
    // ----------------------------------------
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state    <= fir_data_pkg::ENG_IDLE;
            idx      <= '0;
            hist_idx <= '0;
            ptr      <= '0;
            in_cnt   <= '0;
            out_cnt  <= '0;
        end else begin
            case (state)
                fir_data_pkg::ENG_IDLE: begin
                    if (start) begin
                        state   <= fir_data_pkg::ENG_CLEAR;
                        idx     <= '0;
                        ptr     <= '0;
                        in_cnt  <= '0;
                        out_cnt <= '0;
                    end
                end
                // zero tap_num history words
                fir_data_pkg::ENG_CLEAR: begin
                    if (idx == last_idx)
                        state <= fir_data_pkg::ENG_WAIT_IN;
                    else
                        idx <= idx + 1'b1;
                end
                fir_data_pkg::ENG_WAIT_IN: begin
                    if (ss_tvalid && ss_tready) begin
                        in_cnt <= in_cnt + 1'b1;
                        state  <= fir_data_pkg::ENG_WRITE;
                    end
                end
                fir_data_pkg::ENG_WRITE: begin
                    idx      <= '0;
                    hist_idx <= ptr;
                    state    <= fir_data_pkg::ENG_MAC;
                end
                // one extra cycle for the RAM read latency
                fir_data_pkg::ENG_MAC: begin
                    if (idx == cfg.tap_num) begin
                        state <= fir_data_pkg::ENG_OUT;
                    end else begin
                        idx      <= idx + 1'b1;
                        hist_idx <= (hist_idx == '0) ? last_idx : hist_idx - 1'b1;
                    end
                end
                fir_data_pkg::ENG_OUT: begin
                    if (sm_tready) begin
                        out_cnt <= out_cnt + 1'b1;
                        ptr     <= (ptr == last_idx) ? '0 : ptr + 1'b1;
                        state   <= sm_tlast ? fir_data_pkg::ENG_IDLE : fir_data_pkg::ENG_WAIT_IN;
                    end
                end
                default: state <= fir_data_pkg::ENG_IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // datapath
    // ----------------------------------------
    always_ff @(posedge axis_clk) begin
        if (ss_tvalid && ss_tready)
            x_q <= ss_tdata;
        if (state == fir_data_pkg::ENG_WRITE)
            acc <= '0;
        else if (state == fir_data_pkg::ENG_MAC && idx != '0)
            acc <= acc + prod;
        // product of the last tap lands here
        if (state == fir_data_pkg::ENG_MAC && idx == cfg.tap_num)
            sm_tdata <= acc + prod;
    end

    // ss_tlast unused since the length comes from the register
    assign ss_tready   = state == fir_data_pkg::ENG_WAIT_IN && in_cnt < cfg.data_length;
    assign sm_tvalid   = state == fir_data_pkg::ENG_OUT;
    assign sm_tlast    = sm_tvalid && out_cnt + 1'b1 == cfg.data_length;
    assign last_done   = sm_tvalid && sm_tready && sm_tlast;
    assign tap_rd_addr = word_addr(idx);

    always_comb begin
        data_req = '0;
        case (state)
            fir_data_pkg::ENG_CLEAR: begin
                data_req.we   = 4'hf;
                data_req.en   = 1'b1;
                data_req.addr = word_addr(idx);
            end
            fir_data_pkg::ENG_WRITE: begin
                data_req.we   = 4'hf;
                data_req.en   = 1'b1;
                data_req.addr = word_addr(ptr);
                data_req.di   = x_q;
            end
            fir_data_pkg::ENG_MAC: begin
                data_req.en   = 1'b1;
                data_req.addr = word_addr(hist_idx);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: fir.sv
`default_nettype none

`include "fir_params.svh"

module fir (
    output wire                   awready,
    output wire                   wready,
    input  wire                   awvalid,
    input  wire [`FIR_ADDR_W-1:0] awaddr,
    input  wire                   wvalid,
    input  wire [`FIR_DATA_W-1:0] wdata,
    output wire                   arready,
    input  wire                   rready,
    input  wire                   arvalid,
    input  wire [`FIR_ADDR_W-1:0] araddr,
    output wire                   rvalid,
    output wire [`FIR_DATA_W-1:0] rdata,
    input  wire                   ss_tvalid,
    input  wire [`FIR_DATA_W-1:0] ss_tdata,
    input  wire                   ss_tlast,
    output wire                   ss_tready,
    input  wire                   sm_tready,
    output wire                   sm_tvalid,
    output wire [`FIR_DATA_W-1:0] sm_tdata,
    output wire                   sm_tlast,

    // tap RAM
    output wire [3:0]             tap_WE,
    output wire                   tap_EN,
    output wire [`FIR_DATA_W-1:0] tap_Di,
    output wire [`FIR_ADDR_W-1:0] tap_A,
    input  wire [`FIR_DATA_W-1:0] tap_Do,

    // sample history RAM
    output wire [3:0]             data_WE,
    output wire                   data_EN,
    output wire [`FIR_DATA_W-1:0] data_Di,
    output wire [`FIR_ADDR_W-1:0] data_A,
    input  wire [`FIR_DATA_W-1:0] data_Do,

    input  wire                   axis_clk,
    input  wire                   axis_rst_n
);

    wire fir_cfg_pkg::fir_cfg_t    cfg;
    wire fir_cfg_pkg::ap_status_t  status;
    wire fir_data_pkg::bram_req_t  tap_req;
    wire fir_data_pkg::bram_req_t  data_req;
    wire [`FIR_ADDR_W-1:0]         tap_rd_addr;
    wire                           start_req;
    wire                           done_clr;
    wire                           start;
    wire                           busy;
    wire                           last_done;

    fir_axil_regs u_regs (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .awvalid     (awvalid),
        .awaddr      (awaddr),
        .awready     (awready),
        .wvalid      (wvalid),
        .wdata       (wdata),
        .wready      (wready),
        .arvalid     (arvalid),
        .araddr      (araddr),
        .arready     (arready),
        .rvalid      (rvalid),
        .rready      (rready),
        .rdata       (rdata),
        .status      (status),
        .busy        (busy),
        .cfg         (cfg),
        .start_req   (start_req),
        .done_clr    (done_clr),
        .tap_rd_addr (tap_rd_addr),
        .tap_do      (tap_Do),
        .tap_req     (tap_req)
    );

    fir_ap_ctrl u_ctrl (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .start_req  (start_req),
        .done_clr   (done_clr),
        .last_done  (last_done),
        .status     (status),
        .start      (start),
        .busy       (busy)
    );

    fir_mac_engine u_engine (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .start       (start),
        .cfg         (cfg),
        .ss_tvalid   (ss_tvalid),
        .ss_tdata    (ss_tdata),
        .ss_tlast    (ss_tlast),
        .ss_tready   (ss_tready),
        .sm_tready   (sm_tready),
        .sm_tvalid   (sm_tvalid),
        .sm_tdata    (sm_tdata),
        .sm_tlast    (sm_tlast),
        .tap_do      (tap_Do),
        .data_do     (data_Do),
        .tap_rd_addr (tap_rd_addr),
        .data_req    (data_req),
        .last_done   (last_done)
    );

    // unpack the RAM requests
    assign tap_WE  = tap_req.we;
    assign tap_EN  = tap_req.en;
    assign tap_A   = tap_req.addr;
    assign tap_Di  = tap_req.di;
    assign data_WE = data_req.we;
    assign data_EN = data_req.en;
    assign data_A  = data_req.addr;
    assign data_Di = data_req.di;

endmodule

`default_nettype wire

// File: tb_bram.sv
`default_nettype none

`include "fir_params.svh"

module tb_bram (
    input  wire                          axis_clk,
    input  wire fir_data_pkg::bram_req_t req,
    output logic [`FIR_DATA_W-1:0]       dout
);

    localparam int depth = 1 << (`FIR_ADDR_W - 2);

    logic [`FIR_DATA_W-1:0] mem [0:depth-1];
    logic [`FIR_ADDR_W-3:0] word;

    // byte address to word index
    assign word = req.addr[`FIR_ADDR_W-1:2];

    // read before write with one cycle of read latency
    always_ff @(posedge axis_clk) begin
        if (req.en) begin
            for (int b = 0; b < 4; b++) begin
                if (req.we[b])
                    mem[word][8*b +: 8] <= req.di[8*b +: 8];
            end
            dout <= mem[word];
        end
    end

endmodule

`default_nettype wire

// File: tb_fir.sv
`default_nettype none

`include "fir_params.svh"

module tb_fir;

    typedef struct packed {
        int   tap_num;
        int   data_length;
        logic stall;
        int   tap_ofs;
    } row_t;

    localparam int num_rows = 3;
    localparam row_t test_rows [0:num_rows-1] = '{
        '{11, 40, 1'b0, 0},
        '{5, 24, 1'b1, 17},
        '{32, 16, 1'b1, 301}
    };
    localparam integer seed_base = 32'h9ec67553;

    logic                    axis_clk;
    logic                    axis_rst_n;
    logic                    awvalid;
    logic [`FIR_ADDR_W-1:0]  awaddr;
    logic                    wvalid;
    logic [`FIR_DATA_W-1:0]  wdata;
    logic                    arvalid;
    logic [`FIR_ADDR_W-1:0]  araddr;
    logic                    rready;
    logic                    ss_tvalid;
    fir_data_pkg::sample_t   ss_tdata;
    logic                    ss_tlast;
    logic                    sm_tready;
    wire                     awready;
    wire                     wready;
    wire                     arready;
    wire                     rvalid;
    wire [`FIR_DATA_W-1:0]   rdata;
    wire                     ss_tready;
    wire                     sm_tvalid;
    wire [`FIR_DATA_W-1:0]   sm_tdata;
    wire                     sm_tlast;
    wire [3:0]               tap_we;
    wire                     tap_en;
    wire [`FIR_DATA_W-1:0]   tap_di;
    wire [`FIR_ADDR_W-1:0]   tap_a;
    wire [`FIR_DATA_W-1:0]   tap_do;
    wire [3:0]               data_we;
    wire                     data_en;
    wire [`FIR_DATA_W-1:0]   data_di;
    wire [`FIR_ADDR_W-1:0]   data_a;
    wire [`FIR_DATA_W-1:0]   data_do;
    fir_data_pkg::bram_req_t tap_req;
    fir_data_pkg::bram_req_t data_req;

    integer                seed = seed_base;
    fir_data_pkg::sample_t h_mem [0:`FIR_MAX_TAPS-1];
    fir_data_pkg::sample_t x_mem [0:63];
    int                    tests_run = 0;
    int                    tests_failed = 0;
    int                    checks = 0;
    int                    errors = 0;
    int                    errors_at_start = 0;
    string                 current_test;

    fir u_fir (
        .awready (awready),  .wready (wready),   .awvalid (awvalid), .awaddr (awaddr),
        .wvalid  (wvalid),   .wdata  (wdata),    .arready (arready), .rready (rready),
        .arvalid (arvalid),  .araddr (araddr),   .rvalid  (rvalid),  .rdata  (rdata),
        .ss_tvalid (ss_tvalid), .ss_tdata (ss_tdata), .ss_tlast (ss_tlast),
        .ss_tready (ss_tready), .sm_tready (sm_tready), .sm_tvalid (sm_tvalid),
        .sm_tdata (sm_tdata), .sm_tlast (sm_tlast),
        .tap_WE  (tap_we),   .tap_EN  (tap_en),  .tap_Di  (tap_di),  .tap_A  (tap_a),
        .tap_Do  (tap_do),
        .data_WE (data_we),  .data_EN (data_en), .data_Di (data_di), .data_A (data_a),
        .data_Do (data_do),
        .axis_clk (axis_clk), .axis_rst_n (axis_rst_n)
    );

    assign tap_req  = {tap_we, tap_en, tap_a, tap_di};
    assign data_req = {data_we, data_en, data_a, data_di};

    tb_bram u_tap_ram  (.axis_clk (axis_clk), .req (tap_req),  .dout (tap_do));
    tb_bram u_data_ram (.axis_clk (axis_clk), .req (data_req), .dout (data_do));

    initial begin
        axis_clk = 1'b0;
        forever #10 axis_clk = ~axis_clk;
    end

    // ----------------------------------------
    // checks and bookkeeping
    // ----------------------------------------
    task automatic check_sample(input fir_data_pkg::sample_t got,
                                input fir_data_pkg::sample_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_status(input fir_cfg_pkg::ap_status_t got,
                                input fir_cfg_pkg::ap_status_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at time %0t: %s is idle %b done %b start %b, expected %b%b%b",
                     $time, what, got.ap_idle, got.ap_done, got.ap_start,
                     exp.ap_idle, exp.ap_done, exp.ap_start);
        end
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at time %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("problem at time %0t: %s", $time, msg);
    endtask

    task automatic start_test(input string name);
        current_test    = name;
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic finish_test();
        if (errors == errors_at_start) begin
            $display("test %s: ok", current_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", current_test, errors - errors_at_start);
        end
    endtask

    function automatic fir_cfg_pkg::ap_status_t status_of(input logic idle, input logic done);
        fir_cfg_pkg::ap_status_t st;
        st.ap_idle  = idle;
        st.ap_done  = done;
        st.ap_start = 1'b0;
        return st;
    endfunction

    function automatic logic [`FIR_ADDR_W-1:0] tap_addr(input int n);
        return `FIR_ADDR_TAP_BASE + 12'(4 * n);
    endfunction

    // y[n] = sum of h[i] * x[n-i] with x zero before the first sample
    function automatic fir_data_pkg::sample_t golden_y(input int n, input int tn);
        fir_data_pkg::sample_t acc;
        acc = '0;
        for (int i = 0; i < tn; i++) begin
            if (n - i >= 0)
                acc = acc + h_mem[i] * x_mem[n - i];
        end
        return acc;
    endfunction

    // ----------------------------------------
    // bus and stream drivers
    // ----------------------------------------
    task automatic write_reg(input logic [`FIR_ADDR_W-1:0] addr, input logic [31:0] data);
        @(posedge axis_clk);
        awvalid <= 1'b1;
        awaddr  <= addr;
        wvalid  <= 1'b1;
        wdata   <= data;
        do begin
            @(negedge axis_clk);
        end while (!awready);
        if (!wready)
            report_problem("wready did not rise together with awready");
        @(posedge axis_clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
    endtask

    task automatic read_reg(input logic [`FIR_ADDR_W-1:0] addr, output logic [31:0] data);
        @(posedge axis_clk);
        arvalid <= 1'b1;
        araddr  <= addr;
        do begin
            @(negedge axis_clk);
        end while (!arready);
        @(posedge axis_clk);
        arvalid <= 1'b0;
        rready  <= 1'b1;
        do begin
            @(negedge axis_clk);
        end while (!rvalid);
        data = rdata;
        @(posedge axis_clk);
        rready <= 1'b0;
    endtask

    task automatic send_samples(input int len);
        for (int k = 0; k < len; k++) begin
            @(posedge axis_clk);
            ss_tvalid <= 1'b1;
            ss_tdata  <= x_mem[k];
            ss_tlast  <= k == len - 1;
            do begin
                @(negedge axis_clk);
            end while (!ss_tready);
        end
        @(posedge axis_clk);
        ss_tvalid <= 1'b0;
        ss_tlast  <= 1'b0;
    endtask

    task automatic collect_outputs(input int r, input int len, input int tn, input logic stall);
        int   k;
        logic extra;
        k     = 0;
        extra = 1'b0;
        while (k < len) begin
            @(posedge axis_clk);
            sm_tready <= stall ? (($random(seed) & 1) != 0) : 1'b1;
            @(negedge axis_clk);
            if (sm_tvalid && sm_tready) begin
                check_sample(sm_tdata, golden_y(k, tn), $sformatf("row %0d output %0d", r, k));
                if (k == len - 1 && !sm_tlast)
                    report_problem($sformatf("final output %0d of row %0d had no tlast", k, r));
                else if (k < len - 1 && sm_tlast)
                    report_problem($sformatf("tlast came early on output %0d of row %0d", k, r));
                k++;
            end
        end
        @(posedge axis_clk);
        sm_tready <= 1'b0;
        // nothing more may come out
        repeat (20) begin
            @(negedge axis_clk);
            if (sm_tvalid)
                extra = 1'b1;
        end
        if (extra)
            report_problem($sformatf("row %0d produced more outputs than data_length", r));
    endtask

    // ----------------------------------------
    // one table row
    // ----------------------------------------
    task automatic run_row(input int r);
        row_t        row;
        integer      tap_seed;
        logic [31:0] word;
        row      = test_rows[r];
        tap_seed = seed_base + row.tap_ofs;
        for (int n = 0; n < row.tap_num; n++)
            h_mem[n] = $random(tap_seed) % 16;
        for (int n = 0; n < row.data_length; n++)
            x_mem[n] = $random(seed) % 100;

        start_test($sformatf("row %0d config", r));
        write_reg(`FIR_ADDR_DLEN, row.data_length);
        write_reg(`FIR_ADDR_TNUM, row.tap_num);
        for (int n = 0; n < row.tap_num; n++)
            write_reg(tap_addr(n), h_mem[n]);
        read_reg(`FIR_ADDR_DLEN, word);
        check_word(word, row.data_length, "data length readback");
        read_reg(`FIR_ADDR_TNUM, word);
        check_word(word, row.tap_num, "tap count readback");
        for (int n = 0; n < row.tap_num; n++) begin
            read_reg(tap_addr(n), word);
            check_word(word, h_mem[n], $sformatf("tap %0d readback", n));
        end
        finish_test();

        start_test($sformatf("row %0d filter", r));
        write_reg(`FIR_ADDR_CTRL, 32'd1);
        read_reg(`FIR_ADDR_CTRL, word);
        check_status(word[2:0], status_of(1'b0, 1'b0), "status while running");
        read_reg(tap_addr(0), word);
        check_word(word, 32'd0, "tap read while running");
        fork
            send_samples(row.data_length);
            collect_outputs(r, row.data_length, row.tap_num, row.stall);
        join
        finish_test();

        start_test($sformatf("row %0d completion", r));
        read_reg(`FIR_ADDR_CTRL, word);
        check_status(word[2:0], status_of(1'b1, 1'b1), "status after last output");
        read_reg(`FIR_ADDR_CTRL, word);
        check_status(word[2:0], status_of(1'b1, 1'b0), "status after done read");
        finish_test();
    endtask

    initial begin
        logic [31:0] word;
        axis_rst_n <= 1'b0;
        awvalid    <= 1'b0;
        awaddr     <= '0;
        wvalid     <= 1'b0;
        wdata      <= '0;
        arvalid    <= 1'b0;
        araddr     <= '0;
        rready     <= 1'b0;
        ss_tvalid  <= 1'b0;
        ss_tdata   <= '0;
        ss_tlast   <= 1'b0;
        sm_tready  <= 1'b0;
        repeat (10) @(posedge axis_clk);
        axis_rst_n <= 1'b1;

        start_test("reset");
        @(negedge axis_clk);
        check_word({25'd0, awready, wready, arready, rvalid, ss_tready, sm_tvalid, sm_tlast},
                   32'd0, "handshake outputs after reset");
        read_reg(`FIR_ADDR_CTRL, word);
        check_status(word[2:0], status_of(1'b1, 1'b0), "status after reset");
        finish_test();

        for (int r = 0; r < num_rows; r++)
            run_row(r);

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // budget grows with stream length and tap walk
    initial begin
        int limit;
        limit = 2000;
        for (int r = 0; r < num_rows; r++)
            limit += test_rows[r].data_length * (test_rows[r].tap_num + 8) * 4;
        repeat (limit) @(posedge axis_clk);
        $display("watchdog expired after %0d cycles, the tests did not finish", limit);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
fir_cfg_pkg.sv
fir_data_pkg.sv
fir_axil_regs.sv
fir_ap_ctrl.sv
fir_mac_engine.sv
fir.sv
tb_bram.sv
tb_fir.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_fir
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^Verification passed" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
